// ==== verilog/cam_vga_pkg.sv ====
package cam_vga_pkg;

	// ---------------------------------------------------------
	// data widths
	// ---------------------------------------------------------
	localparam int pix565_w = 16;	// one stored pixel, rgb565
	localparam int chan_w   = 8;	// one vga colour channel
	localparam int coord_w  = 12;	// raster x and y

	// ---------------------------------------------------------
	// stored image geometry
	// ---------------------------------------------------------
	localparam int default_img_w = 16;	// pixels per stored line
	localparam int default_img_h = 8;	// stored lines

	// camera byte pairing
	// rgb565 arrives as two bytes, high byte first
	typedef enum logic [1:0]
	{
		wait_frame,	// idle until first vsync edge
		byte_hi,	// next byte is r5 + g[5:3]
		byte_lo		// next byte is g[2:0] + b5
	} cam_state_t;

endpackage

// ==== verilog/camera_reader.sv ====
module camera_reader
#(
	parameter int IMG_W = cam_vga_pkg::default_img_w,
	parameter int IMG_H = cam_vga_pkg::default_img_h
)
(
	input  logic					clk_24m,
	input  logic					rst_n,
	input  logic					cam_pclk,	// pixel strobe, sampled
	input  logic					cam_href,	// line valid
	input  logic					cam_vsync,	// frame start
	input  logic [7:0]				cam_data,
	output logic					cam_xclk,	// clk_24m / 2
	output logic					wr_en,
	output logic [$clog2(IMG_W*IMG_H)-1:0]		wr_addr,
	output logic [cam_vga_pkg::pix565_w-1:0]	wr_data
);

	import cam_vga_pkg::*;

	localparam int ADDR_W = $clog2(IMG_W*IMG_H);
	localparam int COL_W  = $clog2(IMG_W+1);	// holds IMG_W as "line full"
	localparam int ROW_W  = $clog2(IMG_H+1);	// holds IMG_H as "frame full"

	cam_state_t		state;
	logic			xclk_q;
	logic			vsync_d;	// previous vsync sample
	logic			href_d;		// previous href sample
	logic			vs_rise;
	logic			line_end;
	logic			byte_take;
	logic			pix_store;
	logic [7:0]		hi_byte;
	logic [COL_W-1:0]	col;
	logic [ROW_W-1:0]	row;

	assign vs_rise   = cam_vsync & ~vsync_d;	// low then high
	assign line_end  = href_d & ~cam_href;
	assign byte_take = cam_pclk & cam_href;

	// low byte in, still inside the stored image
	assign pix_store = (state == byte_lo) && byte_take && !vs_rise
		&& (col < COL_W'(IMG_W)) && (row < ROW_W'(IMG_H));

	// ---------------------------------------------------------
	// xclk and edge detect
	// ---------------------------------------------------------
	always_ff @(posedge clk_24m)
	begin
		if (!rst_n)
		begin
			xclk_q  <= 1'b0;
			vsync_d <= 1'b1;	// need a real low before the first edge
			href_d  <= 1'b0;
		end
		else
		begin
			xclk_q  <= ~xclk_q;
			vsync_d <= cam_vsync;
			href_d  <= cam_href;
		end
	end

	assign cam_xclk = xclk_q;

	// ---------------------------------------------------------
	// byte pairing FSM, column and row counters
	// ---------------------------------------------------------
	always_ff @(posedge clk_24m)
	begin
		if (!rst_n)
		begin
			state <= wait_frame;
			col   <= '0;
			row   <= '0;
			wr_en <= 1'b0;
		end
		else
		begin
			wr_en <= pix_store;	// one cycle after the low byte
			if (vs_rise)
			begin
				state <= byte_hi;	// arm, restart at address 0
				col   <= '0;
				row   <= '0;
			end
			else if (state != wait_frame)
			begin
				case (state)
					byte_hi: if (byte_take) state <= byte_lo;
					byte_lo: if (!cam_href || byte_take) state <= byte_hi;
					default: state <= state;
				endcase
				if (line_end)
				begin
					col <= '0;
					if (row != ROW_W'(IMG_H))	// saturate, extra lines dropped
						row <= row + 1'b1;
				end
				else if (state == byte_lo && byte_take && col != COL_W'(IMG_W))
					col <= col + 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge clk_24m)
	begin
		if (state == byte_hi && byte_take)
			hi_byte <= cam_data;
		if (pix_store)
		begin
			wr_data <= {hi_byte, cam_data};
			wr_addr <= ADDR_W'(row * IMG_W + col);	// row-major
		end
	end

endmodule

// ==== verilog/frame_buffer.sv ====
module frame_buffer
#(
	parameter int DEPTH = cam_vga_pkg::default_img_w * cam_vga_pkg::default_img_h
)
(
	input  logic					clk_24m,
	// write side, from camera reader
	input  logic					wr_en,
	input  logic [$clog2(DEPTH)-1:0]		wr_addr,
	input  logic [cam_vga_pkg::pix565_w-1:0]	wr_data,
	// read side, from display fetch
	input  logic					rd_en,
	input  logic [$clog2(DEPTH)-1:0]		rd_addr,
	output logic [cam_vga_pkg::pix565_w-1:0]	rd_data
);

	import cam_vga_pkg::*;

	// ---------------------------------------------------------
	// simple dual port ram
	// ---------------------------------------------------------
	logic [pix565_w-1:0]	mem [DEPTH];

	always_ff @(posedge clk_24m)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr];	// old word on same-address collision
	end

endmodule

// ==== verilog/display_timing.sv ====
module display_timing
#(
	parameter int H_ACTIVE = 20,
	parameter int H_FRONT  = 2,
	parameter int H_SYNC   = 3,
	parameter int H_BACK   = 3,
	parameter int V_ACTIVE = 10,
	parameter int V_FRONT  = 1,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 2
)
(
	input  logic					clk_24m,
	input  logic					rst_n,
	output logic					den,		// active area
	output logic [cam_vga_pkg::coord_w-1:0]	xpos,
	output logic [cam_vga_pkg::coord_w-1:0]	ypos,
	output logic					hsync_raw,	// active low
	output logic					vsync_raw	// active low
);

	import cam_vga_pkg::*;

	// line: active, front porch, sync, back porch
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int HS_END   = HS_START + H_SYNC;
	localparam int VS_START = V_ACTIVE + V_FRONT;
	localparam int VS_END   = VS_START + V_SYNC;

	logic [coord_w-1:0]	h_cnt;	// pixel within line
	logic [coord_w-1:0]	v_cnt;	// line within frame
	logic			h_last;
	logic			v_last;
	logic			h_act;
	logic			v_act;
	logic			hs_act;
	logic			vs_act;

	assign h_last = (h_cnt == coord_w'(H_TOTAL - 1));
	assign v_last = (v_cnt == coord_w'(V_TOTAL - 1));
	assign h_act  = (h_cnt < coord_w'(H_ACTIVE));
	assign v_act  = (v_cnt < coord_w'(V_ACTIVE));

	// sync windows
	assign hs_act = (h_cnt >= coord_w'(HS_START)) && (h_cnt < coord_w'(HS_END));
	assign vs_act = (v_cnt >= coord_w'(VS_START)) && (v_cnt < coord_w'(VS_END));

	// ---------------------------------------------------------
	// free running counters
	// ---------------------------------------------------------
	always_ff @(posedge clk_24m)
	begin
		if (!rst_n)
		begin
			h_cnt <= '0;	// first active pixel of line 0
			v_cnt <= '0;
		end
		else if (h_last)
		begin
			h_cnt <= '0;
			if (v_last)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end
		else
			h_cnt <= h_cnt + 1'b1;
	end

	// ---------------------------------------------------------
	// registered decode
	// ---------------------------------------------------------
	always_ff @(posedge clk_24m)
	begin
		if (!rst_n)
		begin
			den       <= 1'b0;
			hsync_raw <= 1'b1;
			vsync_raw <= 1'b1;
		end
		else
		begin
			den       <= h_act & v_act;
			hsync_raw <= ~hs_act;
			vsync_raw <= ~vs_act;	// changes at h_cnt 0, whole lines
		end
	end

	// coordinates, meaningful while den is high
	always_ff @(posedge clk_24m)
	begin
		xpos <= h_cnt;
		ypos <= v_cnt;
	end

endmodule

// ==== verilog/display_fetch.sv ====
module display_fetch
#(
	parameter int IMG_W = cam_vga_pkg::default_img_w,
	parameter int IMG_H = cam_vga_pkg::default_img_h,
	parameter int IMG_X = 2,
	parameter int IMG_Y = 1
)
(
	input  logic					clk_24m,
	input  logic					rst_n,
	// from timing generator
	input  logic					den,
	input  logic [cam_vga_pkg::coord_w-1:0]	xpos,
	input  logic [cam_vga_pkg::coord_w-1:0]	ypos,
	input  logic					hsync_raw,
	input  logic					vsync_raw,
	// frame buffer read port
	output logic					rd_en,
	output logic [$clog2(IMG_W*IMG_H)-1:0]		rd_addr,
	input  logic [cam_vga_pkg::pix565_w-1:0]	rd_data,
	// vga pins
	output logic [cam_vga_pkg::chan_w-1:0]	vga_r,
	output logic [cam_vga_pkg::chan_w-1:0]	vga_g,
	output logic [cam_vga_pkg::chan_w-1:0]	vga_b,
	output logic					vga_hsync,
	output logic					vga_vsync,
	output logic					vga_den
);

	import cam_vga_pkg::*;

	localparam int ADDR_W = $clog2(IMG_W*IMG_H);

	logic			in_win;
	logic [coord_w-1:0]	img_col;	// x inside stored image
	logic [coord_w-1:0]	img_row;	// y inside stored image
	logic			win_d1;
	logic			den_d1;
	logic			hs_d1;
	logic			vs_d1;

	// ---------------------------------------------------------
	// stage 1, window test and read request
	// ---------------------------------------------------------
	assign in_win = den
		&& (xpos >= coord_w'(IMG_X)) && (xpos < coord_w'(IMG_X + IMG_W))
		&& (ypos >= coord_w'(IMG_Y)) && (ypos < coord_w'(IMG_Y + IMG_H));

	assign img_col = xpos - coord_w'(IMG_X);
	assign img_row = ypos - coord_w'(IMG_Y);

	assign rd_en   = in_win;	// ram registers it, data next cycle
	assign rd_addr = ADDR_W'(img_row * IMG_W + img_col);

	always_ff @(posedge clk_24m)
	begin
		if (!rst_n)
		begin
			win_d1 <= 1'b0;
			den_d1 <= 1'b0;
			hs_d1  <= 1'b1;
			vs_d1  <= 1'b1;
		end
		else
		begin
			win_d1 <= in_win;	// lines up with rd_data
			den_d1 <= den;
			hs_d1  <= hsync_raw;
			vs_d1  <= vsync_raw;
		end
	end

	// ---------------------------------------------------------
	// stage 2, rgb565 to rgb888, blanking
	// ---------------------------------------------------------
	always_ff @(posedge clk_24m)
	begin
		if (!rst_n)
		begin
			vga_r     <= '0;
			vga_g     <= '0;
			vga_b     <= '0;
			vga_den   <= 1'b0;
			vga_hsync <= 1'b1;
			vga_vsync <= 1'b1;
		end
		else
		begin
			vga_den   <= den_d1;	// two cycles behind timing
			vga_hsync <= hs_d1;
			vga_vsync <= vs_d1;
			if (win_d1)
			begin
				vga_r <= {rd_data[15:11], 3'b000};
				vga_g <= {rd_data[10:5], 2'b00};
				vga_b <= {rd_data[4:0], 3'b000};
			end
			else
			begin
				vga_r <= '0;	// black outside window
				vga_g <= '0;
				vga_b <= '0;
			end
		end
	end

endmodule

// ==== verilog/test_camera.sv ====
module test_camera
#(
	parameter int IMG_W    = cam_vga_pkg::default_img_w,	// stored image size
	parameter int IMG_H    = cam_vga_pkg::default_img_h,
	parameter int IMG_X    = 2,	// window origin on screen
	parameter int IMG_Y    = 1,
	parameter int H_ACTIVE = 20,
	parameter int H_FRONT  = 2,
	parameter int H_SYNC   = 3,
	parameter int H_BACK   = 3,
	parameter int V_ACTIVE = 10,
	parameter int V_FRONT  = 1,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 2
)
(
	input  logic					clk_24m,
	input  logic					rst_n,
	// camera
	input  logic					cam_pclk,
	output logic					cam_xclk,
	input  logic					cam_href,
	input  logic					cam_vsync,
	output logic					cam_pwdn,
	output logic					cam_rst,
	input  logic [7:0]				cam_data,
	// vga
	output logic [cam_vga_pkg::chan_w-1:0]	vga_r,
	output logic [cam_vga_pkg::chan_w-1:0]	vga_g,
	output logic [cam_vga_pkg::chan_w-1:0]	vga_b,
	output logic					vga_clk,
	output logic					vga_hsync,
	output logic					vga_vsync,
	output logic					vga_den
);

	import cam_vga_pkg::*;

	localparam int DEPTH  = IMG_W * IMG_H;
	localparam int ADDR_W = $clog2(DEPTH);

	// ---------------------------------------------------------
	// camera side wires
	// ---------------------------------------------------------
	logic			wr_en;
	logic [ADDR_W-1:0]	wr_addr;
	logic [pix565_w-1:0]	wr_data;

	// display side wires
	logic			rd_en;
	logic [ADDR_W-1:0]	rd_addr;
	logic [pix565_w-1:0]	rd_data;
	logic			den;
	logic [coord_w-1:0]	xpos;
	logic [coord_w-1:0]	ypos;
	logic			hsync_raw;
	logic			vsync_raw;

	assign cam_pwdn = 1'b0;		// normal mode
	assign cam_rst  = rst_n;
	assign vga_clk  = clk_24m;	// pixel clock straight through

	camera_reader #(.IMG_W(IMG_W), .IMG_H(IMG_H)) camera_reader_inst
	(
		.clk_24m(clk_24m), .rst_n(rst_n),
		.cam_pclk(cam_pclk), .cam_href(cam_href), .cam_vsync(cam_vsync),
		.cam_data(cam_data), .cam_xclk(cam_xclk),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	frame_buffer #(.DEPTH(DEPTH)) frame_buffer_inst
	(
		.clk_24m(clk_24m),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	display_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) display_timing_inst
	(
		.clk_24m(clk_24m), .rst_n(rst_n),
		.den(den), .xpos(xpos), .ypos(ypos),
		.hsync_raw(hsync_raw), .vsync_raw(vsync_raw)
	);

	display_fetch #(.IMG_W(IMG_W), .IMG_H(IMG_H), .IMG_X(IMG_X), .IMG_Y(IMG_Y))
	display_fetch_inst
	(
		.clk_24m(clk_24m), .rst_n(rst_n),
		.den(den), .xpos(xpos), .ypos(ypos),
		.hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_den(vga_den)
	);

endmodule

// ==== sim/tb_camera.sv ====
module tb_camera;

	import cam_vga_pkg::*;

	// ------------------------------------------------------------
	// geometry the DUT is built with
	// ------------------------------------------------------------
	localparam int IMG_W    = default_img_w;
	localparam int IMG_H    = default_img_h;
	localparam int IMG_X    = 2;
	localparam int IMG_Y    = 1;
	localparam int H_ACTIVE = 20;
	localparam int H_FRONT  = 2;
	localparam int H_SYNC   = 3;
	localparam int H_BACK   = 3;
	localparam int V_ACTIVE = 10;
	localparam int V_FRONT  = 1;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 2;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CYC = H_TOTAL * V_TOTAL;

	// upper bound on camera traffic over 4 frames with oversize lines and worst gaps
	localparam int LINE_MAX = (IMG_W + 4) * 8 + 8;
	localparam int STIM_CYC = 4 * ((IMG_H + 2) * LINE_MAX + 16);
	localparam int RUN_CYC  = 20 + STIM_CYC + 11 * FRAME_CYC;	// 3 checked frames + slack

	logic			clk_24m = 1'b0;
	logic			rst_n;
	logic			cam_pclk;
	logic			cam_href;
	logic			cam_vsync;
	logic [7:0]		cam_data;
	logic			cam_xclk;
	logic			cam_pwdn;
	logic			cam_rst;
	logic [chan_w-1:0]	vga_r;
	logic [chan_w-1:0]	vga_g;
	logic [chan_w-1:0]	vga_b;
	logic			vga_clk;
	logic			vga_hsync;
	logic			vga_vsync;
	logic			vga_den;

	int			seed = 83;
	int			errors = 0;
	int			checks = 0;
	logic [pix565_w-1:0]	model [IMG_W*IMG_H];	// expected frame buffer

	// monitor state
	logic			check_pix = 1'b0;	// compare window pixels with model
	int			pix_checked = 0;
	int			frame_cnt = 0;		// vga_vsync falling edges
	logic			hs_prev;
	logic			vs_prev;
	logic			hs_seen;
	int			hs_per;
	int			hs_low;
	int			vs_low;
	int			den_cnt;
	int			pix_x;
	int			pix_y;
	logic [pix565_w-1:0]	pix;
	logic			xclk_exp;	// expected half rate camera clock

	always #2 clk_24m = ~clk_24m;	// period 4

	test_camera #(
		.IMG_W(IMG_W), .IMG_H(IMG_H), .IMG_X(IMG_X), .IMG_Y(IMG_Y),
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) test_camera_inst
	(
		.clk_24m(clk_24m), .rst_n(rst_n),
		.cam_pclk(cam_pclk), .cam_xclk(cam_xclk), .cam_href(cam_href),
		.cam_vsync(cam_vsync), .cam_pwdn(cam_pwdn), .cam_rst(cam_rst),
		.cam_data(cam_data),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_clk(vga_clk),
		.vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_den(vga_den)
	);

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("** Error %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// outputs while the display is still idle
	task automatic check_idle();
		compare("vga_hsync", vga_hsync, 1);
		compare("vga_vsync", vga_vsync, 1);
		compare("vga_den", vga_den, 0);
		compare("vga_rgb", {vga_r, vga_g, vga_b}, 0);
	endtask

	// ------------------------------------------------------------
	// camera side stimulus
	// ------------------------------------------------------------
	task automatic drive_byte(input logic [7:0] b);
		int gap;
		gap = {$random(seed)} % 3;
		repeat (gap)
		begin
			cam_pclk = 1'b0;
			cam_data = $random(seed);	// junk without strobe
			@(negedge clk_24m);
		end
		cam_pclk = 1'b1;
		cam_data = b;
		@(negedge clk_24m);
		cam_pclk = 1'b0;
	endtask

	task automatic send_line(input int row, input int npix, input logic dangling);
		logic [7:0]	hi;
		logic [7:0]	lo;
		cam_href = 1'b1;
		for (int c = 0; c < npix; c++)
		begin
			hi = $random(seed);
			lo = $random(seed);
			drive_byte(hi);
			drive_byte(lo);
			if (row < IMG_H && c < IMG_W)	// beyond the image is dropped
				model[row * IMG_W + c] = {hi, lo};
		end
		if (dangling)
			drive_byte($random(seed));	// lone high byte never stored
		cam_href = 1'b0;
		repeat (2 + {$random(seed)} % 4) @(negedge clk_24m);
	endtask

	// vsync pulse restarts at address 0 before the lines
	task automatic send_frame(input int lines, input int npix);
		cam_vsync = 1'b0;
		repeat (2) @(negedge clk_24m);
		cam_vsync = 1'b1;
		repeat (3) @(negedge clk_24m);
		cam_vsync = 1'b0;
		repeat (3) @(negedge clk_24m);
		for (int l = 0; l < lines; l++)
			send_line(l, npix, {$random(seed)} % 2);
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		while (frame_cnt < target)
			@(negedge clk_24m);
	endtask

	// one whole displayed frame against the model with the camera idle
	task automatic check_frame();
		wait_frames(1);
		pix_checked = 0;
		check_pix = 1'b1;
		wait_frames(1);
		check_pix = 1'b0;
		compare("window_pixels", pix_checked, IMG_W * IMG_H);
	endtask

	// ------------------------------------------------------------
	// camera control pins and pixel clock pass-through
	// ------------------------------------------------------------
	always @(posedge clk_24m)
	begin
		#1;	// a quarter period after the edge
		if (!rst_n)
			xclk_exp = 1'b0;
		else
			xclk_exp = ~xclk_exp;	// clk_24m divided by two
		compare("cam_xclk", cam_xclk, xclk_exp);
		compare("cam_rst", cam_rst, rst_n);
		compare("cam_pwdn", cam_pwdn, 0);
		compare("vga_clk", vga_clk, 1);
		@(negedge clk_24m);
		#1;
		compare("vga_clk", vga_clk, 0);
	end

	// ------------------------------------------------------------
	// VGA monitor sampled mid-cycle
	// ------------------------------------------------------------
	always @(negedge clk_24m)
	begin
		if (!rst_n)
		begin
			hs_prev = 1'b1;
			vs_prev = 1'b1;
			hs_seen = 1'b0;
			hs_per  = 0;
			hs_low  = 0;
			vs_low  = 0;
			den_cnt = 0;
		end
		else
		begin
			if (hs_prev && !vga_hsync)	// hsync falling
			begin
				if (hs_seen)
					compare("hsync_period", hs_per, H_TOTAL);
				hs_seen = 1'b1;
				hs_per  = 0;
			end
			hs_per = hs_per + 1;
			if (!vga_hsync)
				hs_low = hs_low + 1;
			else if (!hs_prev)
			begin
				compare("hsync_width", hs_low, H_SYNC);
				hs_low = 0;
			end
			if (!vga_vsync)
				vs_low = vs_low + 1;
			else if (!vs_prev)
			begin
				compare("vsync_width", vs_low, V_SYNC * H_TOTAL);
				vs_low = 0;
			end
			if (vs_prev && !vga_vsync)	// frame boundary
			begin
				compare("den_per_frame", den_cnt, H_ACTIVE * V_ACTIVE);
				den_cnt   = 0;
				frame_cnt = frame_cnt + 1;
			end
			if (vga_den)
			begin
				pix_x = den_cnt % H_ACTIVE;	// position from den count
				pix_y = den_cnt / H_ACTIVE;
				if (pix_x >= IMG_X && pix_x < IMG_X + IMG_W
					&& pix_y >= IMG_Y && pix_y < IMG_Y + IMG_H)
				begin
					if (check_pix)
					begin
						pix = model[(pix_y - IMG_Y) * IMG_W + pix_x - IMG_X];
						compare("vga_rgb", {vga_r, vga_g, vga_b},
							{pix[15:11], 3'b000, pix[10:5], 2'b00, pix[4:0], 3'b000});
						pix_checked = pix_checked + 1;
					end
				end
				else
					compare("vga_rgb", {vga_r, vga_g, vga_b}, 0);	// border
				den_cnt = den_cnt + 1;
			end
			else
				compare("vga_rgb", {vga_r, vga_g, vga_b}, 0);	// blanking
			hs_prev = vga_hsync;
			vs_prev = vga_vsync;
		end
	end

	// watchdog
	initial
	begin
		#(RUN_CYC * 4 * 2);
		$display("timeout: run did not finish within %0d cycles", RUN_CYC * 2);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Test FAILED");
		$finish;
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial
	begin
		rst_n     = 1'b0;
		cam_pclk  = 1'b0;
		cam_href  = 1'b0;
		cam_vsync = 1'b0;
		cam_data  = 8'h00;
		repeat (10) @(negedge clk_24m);
		check_idle();
		rst_n = 1'b1;
		repeat (2)
		begin
			@(negedge clk_24m);
			check_idle();	// den not yet through the pipe
		end

		send_frame(IMG_H + 2, IMG_W + 3);	// extra lines and pixels
		check_frame();

		send_frame(IMG_H / 2 - 1, IMG_W - 5);	// short frame
		send_frame(2, IMG_W);			// restart overwrites the top
		check_frame();

		send_frame(IMG_H, IMG_W);
		check_frame();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
verilog/cam_vga_pkg.sv
verilog/camera_reader.sv
verilog/frame_buffer.sv
verilog/display_timing.sv
verilog/display_fetch.sv
verilog/test_camera.sv
sim/tb_camera.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the camera to VGA testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_camera

verilator --binary --timing -Wno-fatal -f project.f \
	--top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the log
if grep -q "Test FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation passed"
exit 0
